// ==== src/fetch_pkg.sv ====
/*
  Fetch-side definitions for the instruction front end.
  Address and instruction word types, the prefetch buffer depth
  and the tagged entry that the prefetch FIFO carries.
*/

package fetch_pkg;

  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned INSTR_W     = 32;
  localparam int unsigned INSTR_BYTES = INSTR_W / 8;

  // Prefetch buffer depth, also the limit on words in flight
  localparam int unsigned FETCH_DEPTH = 4;
  localparam int unsigned FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned FETCH_PTR_W = $clog2(FETCH_DEPTH);

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [INSTR_W-1:0]     instr_t;

  // Occupancy from 0 to FETCH_DEPTH inclusive
  typedef logic [FETCH_CNT_W-1:0] fifo_cnt_t;
  typedef logic [FETCH_PTR_W-1:0] fifo_ptr_t;

  // One returned word together with the address it was fetched from
  typedef struct packed {
    addr_t  addr;
    instr_t instr;
  } fetch_entry_t;

endpackage

// ==== src/decode_pkg.sv ====
/*
  Decode-side definitions for the instruction classifier.
  RV32I major opcodes, the opcode class encoding, the illegal
  word counter and the classified instruction record.
*/

package decode_pkg;

  localparam int unsigned OPC_W         = 7;
  localparam int unsigned ILLEGAL_CNT_W = 16;

  typedef logic [OPC_W-1:0] opcode_t;

  // Standard RV32I major opcodes, bits [6:0] of the word
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  typedef enum logic [3:0] {
    CLS_LOAD     = 4'd0,
    CLS_STORE    = 4'd1,
    CLS_OP_IMM   = 4'd2,
    CLS_OP       = 4'd3,
    CLS_LUI      = 4'd4,
    CLS_AUIPC    = 4'd5,
    CLS_JAL      = 4'd6,
    CLS_JALR     = 4'd7,
    CLS_BRANCH   = 4'd8,
    CLS_MISC_MEM = 4'd9,
    CLS_SYSTEM   = 4'd10,
    CLS_ILLEGAL  = 4'd15
  } opclass_e;

  // Saturating count of illegal words
  typedef logic [ILLEGAL_CNT_W-1:0] illegal_cnt_t;

  typedef struct packed {
    fetch_pkg::addr_t  pc;
    fetch_pkg::instr_t instr;
    opclass_e          cls;
  } classified_t;

endpackage

// ==== src/prefetch_controller.sv ====
/*
  Prefetch controller.
  Walks sequential word addresses from the boot address and issues
  requests on the instruction memory port. Words in flight plus
  buffered words are kept below the FIFO depth, and each response
  is tagged with the address it belongs to before it is pushed.
*/

`timescale 1ns/1ps

module prefetch_controller (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    fetch_enable_i,
  input  fetch_pkg::addr_t        boot_addr_i,
  output logic                    instr_req_o,
  input  logic                    instr_gnt_i,
  output fetch_pkg::addr_t        instr_addr_o,
  input  logic                    instr_rvalid_i,
  input  fetch_pkg::instr_t       instr_rdata_i,
  input  fetch_pkg::fifo_cnt_t    fifo_cnt_i,
  output logic                    push_o,
  output fetch_pkg::fetch_entry_t push_entry_o
);

  import fetch_pkg::*;

  // One extra bit so the sum of two counts cannot wrap
  typedef logic [FETCH_CNT_W:0] inflight_t;

  addr_t     req_addr_q;
  addr_t     rsp_addr_q;
  fifo_cnt_t outstanding_q;
  logic      req_pending_q;
  inflight_t in_flight;
  logic      room;
  logic      grant;

  assign in_flight = inflight_t'(outstanding_q) + inflight_t'(fifo_cnt_i);
  assign room      = in_flight < inflight_t'(FETCH_DEPTH);

  // A request that is already up stays up until granted, even when
  // fetch_enable_i drops meanwhile
  assign instr_req_o  = req_pending_q | (fetch_enable_i & room);
  assign instr_addr_o = req_addr_q;
  assign grant        = instr_req_o & instr_gnt_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_pending_q <= 1'b0;
      req_addr_q    <= boot_addr_i;
    end else begin
      req_pending_q <= instr_req_o & ~instr_gnt_i;
      if (grant) begin
        req_addr_q <= req_addr_q + addr_t'(INSTR_BYTES);
      end
    end
  end

  // Grants not yet answered by rvalid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= '0;
    end else begin
      case ({grant, instr_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + fifo_cnt_t'(1);
        2'b01:   outstanding_q <= outstanding_q - fifo_cnt_t'(1);
        default: outstanding_q <= outstanding_q;
      endcase
    end
  end

  // Responses come back in order, so a second address counter tags them
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_addr_q <= boot_addr_i;
    end else if (instr_rvalid_i) begin
      rsp_addr_q <= rsp_addr_q + addr_t'(INSTR_BYTES);
    end
  end

  assign push_o             = instr_rvalid_i;
  assign push_entry_o.addr  = rsp_addr_q;
  assign push_entry_o.instr = instr_rdata_i;

endmodule

// ==== src/prefetch_fifo.sv ====
/*
  Prefetch FIFO.
  Circular buffer of tagged fetch entries with read and write
  pointers and an occupancy count fed back to the controller.
  The controller's limit keeps it from overflowing.
*/

`timescale 1ns/1ps

module prefetch_fifo (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  input  logic                    pop_i,
  output fetch_pkg::fetch_entry_t head_o,
  output logic                    empty_o,
  output fetch_pkg::fifo_cnt_t    count_o
);

  import fetch_pkg::*;

  fetch_entry_t mem_q [FETCH_DEPTH];
  fifo_ptr_t    wr_ptr_q;
  fifo_ptr_t    rd_ptr_q;
  fifo_cnt_t    count_q;

  function automatic fifo_ptr_t ptr_next(fifo_ptr_t ptr);
    fifo_ptr_t nxt;
    if (ptr == fifo_ptr_t'(FETCH_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + fifo_ptr_t'(1);
    end
    return nxt;
  endfunction

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Push and pop together leave the count alone
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + fifo_cnt_t'(1);
        2'b01:   count_q <= count_q - fifo_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

endmodule

// ==== src/instr_classifier.sv ====
/*
  Instruction classifier.
  Pops the FIFO head, sorts the word into an RV32I opcode class and
  loads pc, word and class into a one-entry output register that
  holds while the issue stage stalls. Illegal words are counted.
*/

`timescale 1ns/1ps

module instr_classifier (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  fetch_pkg::fetch_entry_t head_i,
  input  logic                    empty_i,
  output logic                    pop_o,
  input  logic                    issue_ready_i,
  output logic                    dec_valid_o,
  output decode_pkg::classified_t dec_o,
  output decode_pkg::illegal_cnt_t illegal_cnt_o
);

  import fetch_pkg::*;
  import decode_pkg::*;

  classified_t  dec_q;
  logic         dec_valid_q;
  illegal_cnt_t illegal_cnt_q;
  opclass_e     head_cls;

  function automatic opclass_e classify(instr_t word);
    opclass_e cls;
    cls = CLS_ILLEGAL;
    // Compressed encodings are not supported
    if (word[1:0] == 2'b11) begin
      case (opcode_t'(word[OPC_W-1:0]))
        OPC_LOAD:     cls = CLS_LOAD;
        OPC_STORE:    cls = CLS_STORE;
        OPC_OP_IMM:   cls = CLS_OP_IMM;
        OPC_OP:       cls = CLS_OP;
        OPC_LUI:      cls = CLS_LUI;
        OPC_AUIPC:    cls = CLS_AUIPC;
        OPC_JAL:      cls = CLS_JAL;
        OPC_JALR:     cls = CLS_JALR;
        OPC_BRANCH:   cls = CLS_BRANCH;
        OPC_MISC_MEM: cls = CLS_MISC_MEM;
        OPC_SYSTEM:   cls = CLS_SYSTEM;
        default:      cls = CLS_ILLEGAL;
      endcase
    end
    return cls;
  endfunction

  assign head_cls = classify(head_i.instr);

  // Take a new entry when the output register is free or being drained
  assign pop_o = ~empty_i & (~dec_valid_q | issue_ready_i);

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      dec_q.pc    <= head_i.addr;
      dec_q.instr <= head_i.instr;
      dec_q.cls   <= head_cls;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_valid_q <= 1'b0;
    end else if (pop_o) begin
      dec_valid_q <= 1'b1;
    end else if (issue_ready_i) begin
      dec_valid_q <= 1'b0;
    end
  end

  // Counts at the edge that loads the illegal word, sticks at all ones
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      illegal_cnt_q <= '0;
    end else if (pop_o && head_cls == CLS_ILLEGAL && illegal_cnt_q != '1) begin
      illegal_cnt_q <= illegal_cnt_q + illegal_cnt_t'(1);
    end
  end

  assign dec_valid_o   = dec_valid_q;
  assign dec_o         = dec_q;
  assign illegal_cnt_o = illegal_cnt_q;

endmodule

// ==== src/fetch_subsystem.sv ====
/*
  Instruction fetch subsystem.
  Prefetch controller, prefetch FIFO and instruction classifier
  between the instruction memory port and the issue stage.
*/

`timescale 1ns/1ps

module fetch_subsystem (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     fetch_enable_i,
  input  fetch_pkg::addr_t         boot_addr_i,

  // Instruction memory port
  output logic                     instr_req_o,
  input  logic                     instr_gnt_i,
  output fetch_pkg::addr_t         instr_addr_o,
  input  logic                     instr_rvalid_i,
  input  fetch_pkg::instr_t        instr_rdata_i,

  // Issue stage
  input  logic                     issue_ready_i,
  output logic                     dec_valid_o,
  output decode_pkg::classified_t  dec_o,
  output decode_pkg::illegal_cnt_t illegal_cnt_o
);

  import fetch_pkg::*;

  logic         push;
  fetch_entry_t push_entry;
  fifo_cnt_t    fifo_cnt;
  fetch_entry_t head;
  logic         empty;
  logic         pop;

  prefetch_controller prefetch_controller_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fifo_cnt_i     ( fifo_cnt       ),
    .push_o         ( push           ),
    .push_entry_o   ( push_entry     )
  );

  prefetch_fifo prefetch_fifo_i (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .push_i       ( push       ),
    .push_entry_i ( push_entry ),
    .pop_i        ( pop        ),
    .head_o       ( head       ),
    .empty_o      ( empty      ),
    .count_o      ( fifo_cnt   )
  );

  instr_classifier instr_classifier_i (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .head_i        ( head          ),
    .empty_i       ( empty         ),
    .pop_o         ( pop           ),
    .issue_ready_i ( issue_ready_i ),
    .dec_valid_o   ( dec_valid_o   ),
    .dec_o         ( dec_o         ),
    .illegal_cnt_o ( illegal_cnt_o )
  );

endmodule

// ==== test/fetch_subsystem_checker.sv ====
/*
  Protocol checker for the fetch subsystem.
  Concurrent assertions on the instruction memory handshake,
  the issue stall and the prefetch FIFO occupancy.
*/

`timescale 1ns/1ps

module fetch_subsystem_checker (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    req_i,
  input logic                    gnt_i,
  input fetch_pkg::addr_t        addr_i,
  input logic                    rvalid_i,
  input logic                    issue_ready_i,
  input logic                    dec_valid_i,
  input decode_pkg::classified_t dec_i,
  input fetch_pkg::fifo_cnt_t    fifo_cnt_i
);

  import fetch_pkg::*;

  int unsigned outstanding;
  int unsigned violations = 0;

  // Grants not yet answered, tracked apart from the controller
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding <= 0;
    end else if (req_i && gnt_i && !rvalid_i) begin
      outstanding <= outstanding + 1;
    end else if (rvalid_i && !(req_i && gnt_i)) begin
      outstanding <= outstanding - 1;
    end
  end

  property req_held_until_grant;
    @(posedge clk_i) disable iff (reset_i)
      req_i && !gnt_i |=> req_i && $stable(addr_i);
  endproperty

  property rvalid_needs_grant;
    @(posedge clk_i) disable iff (reset_i)
      rvalid_i |-> outstanding != 0;
  endproperty

  property dec_held_under_stall;
    @(posedge clk_i) disable iff (reset_i)
      dec_valid_i && !issue_ready_i |=> dec_valid_i && $stable(dec_i);
  endproperty

  property fifo_within_depth;
    @(posedge clk_i) disable iff (reset_i)
      fifo_cnt_i <= fifo_cnt_t'(FETCH_DEPTH);
  endproperty

  assert property (req_held_until_grant) else begin
    $error("Request or address changed while waiting for a grant");
    violations++;
  end

  assert property (rvalid_needs_grant) else begin
    $error("Response valid without an outstanding grant");
    violations++;
  end

  assert property (dec_held_under_stall) else begin
    $error("Classifier output changed while the issue stage stalled");
    violations++;
  end

  assert property (fifo_within_depth) else begin
    $error("Prefetch FIFO count above its depth");
    violations++;
  end

endmodule

bind fetch_subsystem fetch_subsystem_checker protocol_checker (
  .clk_i         ( clk_i          ),
  .reset_i       ( reset_i        ),
  .req_i         ( instr_req_o    ),
  .gnt_i         ( instr_gnt_i    ),
  .addr_i        ( instr_addr_o   ),
  .rvalid_i      ( instr_rvalid_i ),
  .issue_ready_i ( issue_ready_i  ),
  .dec_valid_i   ( dec_valid_o    ),
  .dec_i         ( dec_o          ),
  .fifo_cnt_i    ( fifo_cnt       )
);

// ==== test/tb_fetch_subsystem.sv ====
/*
  Testbench for the instruction fetch subsystem.
  A memory model with random grant and response delays serves words
  from a pattern file, the issue stage stalls at random, and every
  accepted result is checked for address, word and class.
*/

`timescale 1ns/1ps

module tb_fetch_subsystem;

  import fetch_pkg::*;
  import decode_pkg::*;

  localparam addr_t       BOOT_ADDR      = 32'h0000_1000;
  localparam int          PATTERN_MAX    = 64;
  localparam int          STALL_AT       = 6;
  localparam int          STALL_CYCLES   = 40;
  localparam int          IDLE_CYCLES    = 30;
  localparam int          WAIT_LIMIT     = 200;
  localparam logic [31:0] NO_ENTRY       = 32'hffff_ffff;
  // Words past the table are OP-IMM with an address dependent immediate
  localparam logic [6:0]  FILL_OPCODE    = 7'b0010011;
  localparam logic [3:0]  FILL_CLASS     = 4'h2;

  logic         clk_i          = 1'b0;
  logic         reset_i        = 1'b1;
  logic         fetch_enable_i = 1'b0;
  addr_t        boot_addr_i    = BOOT_ADDR;
  logic         instr_req_o;
  logic         instr_gnt_i    = 1'b0;
  addr_t        instr_addr_o;
  logic         instr_rvalid_i = 1'b0;
  instr_t       instr_rdata_i  = '0;
  logic         issue_ready_i  = 1'b0;
  logic         dec_valid_o;
  classified_t  dec_o;
  illegal_cnt_t illegal_cnt_o;

  // Even slots hold the words, odd slots their class codes
  logic [31:0] patterns [2*PATTERN_MAX];
  int unsigned num_patterns;
  int unsigned exp_illegal;

  int          seed       = 6;
  int          cycle_cnt  = 0;
  int          wait_cnt   = 0;
  int          last_ready = 0;
  int          rsp_delay;
  int          ready_at;
  addr_t       rsp_addr_q [$];
  int          rsp_ready_q [$];
  int unsigned grant_cnt  = 0;
  logic        stall_hold = 1'b0;
  int unsigned accepted   = 0;
  int unsigned final_grants;

  fetch_subsystem uut (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .issue_ready_i  ( issue_ready_i  ),
    .dec_valid_o    ( dec_valid_o    ),
    .dec_o          ( dec_o          ),
    .illegal_cnt_o  ( illegal_cnt_o  )
  );

  always #4 clk_i = ~clk_i;

  function automatic instr_t memory_word(input addr_t addr);
    int unsigned idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (idx < num_patterns) begin
      return patterns[2*idx];
    end
    return {addr[31:7] ^ addr[24:0], FILL_OPCODE};
  endfunction

  function automatic logic [3:0] expected_class(input int unsigned n);
    if (n < num_patterns) begin
      return patterns[2*n+1][3:0];
    end
    return FILL_CLASS;
  endfunction

  // The memory grants after 0 to 2 waiting cycles and answers in order
  // 1 to 3 cycles after each grant. The issue stage stalls at random
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (reset_i) begin
      wait_cnt   = 0;
      last_ready = cycle_cnt;
      rsp_addr_q.delete();
      rsp_ready_q.delete();
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      issue_ready_i  <= 1'b0;
    end else begin
      if (instr_req_o === 1'b1 && instr_gnt_i) begin
        // Granted addresses walk the words from the boot address
        check_equal("instr_addr_o", BOOT_ADDR + addr_t'(grant_cnt << 2), instr_addr_o);
        rsp_delay = 1 + ($unsigned($random(seed)) % 3);
        ready_at  = cycle_cnt + rsp_delay - 1;
        if (ready_at <= last_ready) begin
          ready_at = last_ready + 1;
        end
        last_ready = ready_at;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_ready_q.push_back(ready_at);
        grant_cnt <= grant_cnt + 1;
        wait_cnt = $unsigned($random(seed)) % 3;
      end else if (instr_req_o === 1'b1 && wait_cnt > 0) begin
        wait_cnt--;
      end
      instr_gnt_i <= (wait_cnt == 0);
      if (rsp_ready_q.size() > 0 && rsp_ready_q[0] <= cycle_cnt) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= memory_word(rsp_addr_q.pop_front());
        void'(rsp_ready_q.pop_front());
      end else begin
        instr_rvalid_i <= 1'b0;
      end
      issue_ready_i <= stall_hold ? 1'b0 : (($unsigned($random(seed)) % 3) != 0);
    end
  end

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_result(input int unsigned n);
    addr_t exp_pc;
    exp_pc = BOOT_ADDR + addr_t'(n << 2);
    check_equal("dec_o.pc", exp_pc, dec_o.pc);
    check_equal("dec_o.instr", memory_word(exp_pc), dec_o.instr);
    check_equal("dec_o.cls", 32'(expected_class(n)), 32'(dec_o.cls));
  endtask

  // Advance one clock edge and check a result taken at it
  task automatic step_cycle();
    @(posedge clk_i);
    if (dec_valid_o && issue_ready_i) begin
      check_result(accepted);
      accepted++;
    end
  endtask

  task automatic expect_next_result();
    int unsigned target;
    int          waited;
    target = accepted + 1;
    waited = 0;
    while (accepted < target) begin
      if (waited >= WAIT_LIMIT) begin
        $display("Timeout: no result accepted within %0d cycles", WAIT_LIMIT);
        abort_run();
      end
      step_cycle();
      waited++;
    end
  endtask

  task automatic wait_request_low();
    int waited;
    waited = 0;
    step_cycle();
    while (instr_req_o !== 1'b0) begin
      if (waited >= WAIT_LIMIT) begin
        $display("Timeout: instr_req_o stayed high after fetch_enable_i was lowered");
        abort_run();
      end
      step_cycle();
      waited++;
    end
  endtask

  initial begin
    for (int i = 0; i < 2*PATTERN_MAX; i++) begin
      patterns[i] = NO_ENTRY;
    end
    $readmemh("test/fetch_patterns.hex", patterns);
    num_patterns = 0;
    exp_illegal  = 0;
    while (num_patterns < PATTERN_MAX && patterns[2*num_patterns+1] != NO_ENTRY) begin
      if (patterns[2*num_patterns+1][3:0] == 4'hf) begin
        exp_illegal++;
      end
      num_patterns++;
    end
    if (num_patterns <= STALL_AT) begin
      $display("Pattern file is missing or holds too few words");
      abort_run();
    end

    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_equal("instr_req_o", 32'd0, 32'(instr_req_o));
    check_equal("dec_valid_o", 32'd0, 32'(dec_valid_o));
    check_equal("illegal_cnt_o", 32'd0, 32'(illegal_cnt_o));

    // Nothing may be requested while fetch is disabled
    repeat (10) begin
      step_cycle();
      check_equal("instr_req_o", 32'd0, 32'(instr_req_o));
    end

    fetch_enable_i <= 1'b1;
    while (accepted < STALL_AT) begin
      expect_next_result();
    end

    // Long stall fills the FIFO and the output register
    stall_hold <= 1'b1;
    repeat (STALL_CYCLES) step_cycle();
    check_equal("instr_req_o", 32'd0, 32'(instr_req_o));
    check_equal("dec_valid_o", 32'd1, 32'(dec_valid_o));
    check_equal("grants - accepted", 32'(FETCH_DEPTH + 1), 32'(grant_cnt - accepted));
    stall_hold <= 1'b0;
    while (accepted < num_patterns) begin
      expect_next_result();
    end

    // Granted words still drain in order once fetching stops
    fetch_enable_i <= 1'b0;
    wait_request_low();
    final_grants = grant_cnt;
    while (accepted < final_grants) begin
      expect_next_result();
    end
    repeat (IDLE_CYCLES) begin
      step_cycle();
      check_equal("instr_req_o", 32'd0, 32'(instr_req_o));
      check_equal("dec_valid_o", 32'd0, 32'(dec_valid_o));
    end
    check_equal("grant count", final_grants, grant_cnt);
    check_equal("illegal_cnt_o", exp_illegal, 32'(illegal_cnt_o));

    if (uut.protocol_checker.violations == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times", uut.protocol_checker.violations);
      abort_run();
    end
  end

endmodule

// ==== test/fetch_patterns.hex ====
// Columns: instruction word, expected class code (0 load .. a system, f illegal)
// Word n is fetched from the boot address plus 4n
00000013 2
00002083 0
00112223 1
002081b3 3
123452b7 4
00000317 5
008000ef 6
00008067 7
00208463 8
0ff0000f 9
00000073 a
00000001 f
0000007f f
ffff0000 f
0000005b f
00a00513 2
40208233 3
00c02283 0

// ==== src.f ====
src/fetch_pkg.sv
src/decode_pkg.sv
src/prefetch_controller.sv
src/prefetch_fifo.sv
src/instr_classifier.sv
src/fetch_subsystem.sv
test/fetch_subsystem_checker.sv
test/tb_fetch_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_subsystem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

SOURCES := $(wildcard src/*.sv test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
